// ==== verilog/eth_pkg.sv ====
package eth_pkg;

    // two input ports
    localparam int port_count = 2;

    // payload bytes held per port buffer
    localparam int fifo_depth = 16;
    localparam int fifo_ptr_w = $clog2(fifo_depth);

    // dest mac + src mac + ethertype
    localparam int hdr_bytes = 14;

    typedef logic [47:0] mac_t;
    typedef logic [15:0] ethtype_t;
    typedef logic [7:0]  byte_t;
    typedef logic [$clog2(port_count)-1:0] port_sel_t;

    typedef logic [fifo_ptr_w-1:0] fifo_ptr_t;
    typedef logic [fifo_ptr_w:0]   fifo_cnt_t;
    typedef logic [$clog2(hdr_bytes)-1:0] hdr_cnt_t;

    typedef enum logic [1:0] {
        ser_idle,
        ser_header,
        ser_payload
    } ser_state_t;

endpackage

// ==== verilog/eth_frame_if.sv ====
`timescale 1ns/10ps

interface eth_frame_if;
    import eth_pkg::*;

    // header channel
    logic     hdr_valid;
    logic     hdr_ready;
    mac_t     dest_mac;
    mac_t     src_mac;
    ethtype_t eth_type;

    // payload channel, one byte per beat
    byte_t    data;
    logic     valid;
    logic     ready;
    logic     last;

    modport source (
        output hdr_valid, dest_mac, src_mac, eth_type,
        output data, valid, last,
        input  hdr_ready, ready
    );

    modport sink (
        input  hdr_valid, dest_mac, src_mac, eth_type,
        input  data, valid, last,
        output hdr_ready, ready
    );

endinterface

// ==== verilog/eth_frame_fifo.sv ====
`timescale 1ns/10ps

module eth_frame_fifo (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_hdr_valid,
    output logic              in_hdr_ready,
    input  eth_pkg::mac_t     in_dest_mac,
    input  eth_pkg::mac_t     in_src_mac,
    input  eth_pkg::ethtype_t in_type,
    input  eth_pkg::byte_t    in_data,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic              in_last,
    eth_frame_if.source       out
);
    import eth_pkg::*;

    // single header slot
    logic      hdr_full;
    mac_t      hdr_dest;
    mac_t      hdr_src;
    ethtype_t  hdr_type;

    // payload store with its last flags
    byte_t     mem_data [fifo_depth];
    logic      mem_last [fifo_depth];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;

    // registered read stage
    logic      rd_valid;
    byte_t     rd_data;
    logic      rd_last;

    // inputs stay closed until one cycle after reset
    logic      in_open;

    logic      hdr_push;
    logic      push;
    logic      pop;

    assign in_hdr_ready = in_open && !hdr_full;
    assign hdr_push     = in_hdr_valid && in_hdr_ready;

    assign in_ready = in_open && (count != fifo_cnt_t'(fifo_depth));
    assign push     = in_valid && in_ready;
    // refill the read stage when it is empty or being drained
    assign pop      = (count != '0) && (!rd_valid || out.ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            in_open  <= 1'b0;
            hdr_full <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            in_open <= 1'b1;
            if (hdr_push) begin
                hdr_full <= 1'b1;
            end else if (out.hdr_valid && out.hdr_ready) begin
                hdr_full <= 1'b0;
            end
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + fifo_cnt_t'(push) - fifo_cnt_t'(pop);
            if (pop) begin
                rd_valid <= 1'b1;
            end else if (out.ready) begin
                rd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_push) begin
            hdr_dest <= in_dest_mac;
            hdr_src  <= in_src_mac;
            hdr_type <= in_type;
        end
        if (push) begin
            mem_data[wr_ptr] <= in_data;
            mem_last[wr_ptr] <= in_last;
        end
        if (pop) begin
            rd_data <= mem_data[rd_ptr];
            rd_last <= mem_last[rd_ptr];
        end
    end

    assign out.hdr_valid = hdr_full;
    assign out.dest_mac  = hdr_dest;
    assign out.src_mac   = hdr_src;
    assign out.eth_type  = hdr_type;
    assign out.data      = rd_data;
    assign out.valid     = rd_valid;
    assign out.last      = rd_last;

endmodule

// ==== verilog/eth_mux.sv ====
`timescale 1ns/10ps

module eth_mux (
    input  logic               clk,
    input  logic               rst,
    eth_frame_if.sink          s0,
    eth_frame_if.sink          s1,
    eth_frame_if.source        m,
    input  logic               enable,
    input  eth_pkg::port_sel_t select
);
    import eth_pkg::*;

    // input ports gathered into arrays for indexing
    logic     hdr_valid_v [port_count];
    mac_t     dest_v [port_count];
    mac_t     src_v [port_count];
    ethtype_t type_v [port_count];
    byte_t    data_v [port_count];
    logic     valid_v [port_count];
    logic     last_v [port_count];

    port_sel_t sel_r;
    port_sel_t sel_next;
    logic      frame_r;
    logic      frame_next;
    logic      start;

    logic [port_count-1:0] hdr_ready_r;
    logic [port_count-1:0] hdr_ready_next;
    logic [port_count-1:0] pay_ready_r;
    logic [port_count-1:0] pay_ready_next;

    logic     m_hdr_valid_r;
    logic     m_hdr_valid_next;
    mac_t     m_dest_r;
    mac_t     m_src_r;
    ethtype_t m_type_r;

    // payload of the chosen port
    byte_t cur_data;
    logic  cur_valid;
    logic  cur_ready;
    logic  cur_last;
    logic  int_valid;

    // skid stage, output register plus temp register
    logic  ready_int_r;
    logic  ready_early;
    logic  out_valid_r;
    logic  out_valid_next;
    byte_t out_data_r;
    logic  out_last_r;
    logic  tmp_valid_r;
    logic  tmp_valid_next;
    byte_t tmp_data_r;
    logic  tmp_last_r;
    logic  store_int_out;
    logic  store_int_tmp;
    logic  store_tmp_out;

    assign hdr_valid_v[0] = s0.hdr_valid;
    assign hdr_valid_v[1] = s1.hdr_valid;
    assign dest_v[0]      = s0.dest_mac;
    assign dest_v[1]      = s1.dest_mac;
    assign src_v[0]       = s0.src_mac;
    assign src_v[1]       = s1.src_mac;
    assign type_v[0]      = s0.eth_type;
    assign type_v[1]      = s1.eth_type;
    assign data_v[0]      = s0.data;
    assign data_v[1]      = s1.data;
    assign valid_v[0]     = s0.valid;
    assign valid_v[1]     = s1.valid;
    assign last_v[0]      = s0.last;
    assign last_v[1]      = s1.last;

    assign s0.hdr_ready = hdr_ready_r[0];
    assign s1.hdr_ready = hdr_ready_r[1];
    assign s0.ready     = pay_ready_r[0];
    assign s1.ready     = pay_ready_r[1];

    assign cur_data  = data_v[sel_r];
    assign cur_valid = valid_v[sel_r];
    assign cur_ready = pay_ready_r[sel_r];
    assign cur_last  = last_v[sel_r];
    assign int_valid = cur_valid && cur_ready && frame_r;

    assign start = !frame_r && enable && !m_hdr_valid_r && hdr_valid_v[select];

    // input may be ready next cycle unless the temp register would fill
    assign ready_early = m.ready || (!tmp_valid_r && (!out_valid_r || !int_valid));

    always_comb begin
        sel_next         = sel_r;
        frame_next       = frame_r;
        hdr_ready_next   = '0;
        m_hdr_valid_next = m_hdr_valid_r && !m.hdr_ready;
        if (cur_valid && cur_ready && cur_last) begin
            frame_next = 1'b0;
        end
        if (start) begin
            frame_next             = 1'b1;
            sel_next               = select;
            hdr_ready_next[select] = 1'b1;
            m_hdr_valid_next       = 1'b1;
        end
        pay_ready_next           = '0;
        pay_ready_next[sel_next] = ready_early && frame_next;
    end

    always_comb begin
        out_valid_next = out_valid_r;
        tmp_valid_next = tmp_valid_r;
        store_int_out  = 1'b0;
        store_int_tmp  = 1'b0;
        store_tmp_out  = 1'b0;
        if (ready_int_r) begin
            if (m.ready || !out_valid_r) begin
                out_valid_next = int_valid;
                store_int_out  = 1'b1;
            end else begin
                tmp_valid_next = int_valid;
                store_int_tmp  = 1'b1;
            end
        end else if (m.ready) begin
            // drain temp into the output register
            out_valid_next = tmp_valid_r;
            tmp_valid_next = 1'b0;
            store_tmp_out  = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_r         <= '0;
            frame_r       <= 1'b0;
            hdr_ready_r   <= '0;
            pay_ready_r   <= '0;
            m_hdr_valid_r <= 1'b0;
            ready_int_r   <= 1'b0;
            out_valid_r   <= 1'b0;
            tmp_valid_r   <= 1'b0;
        end else begin
            sel_r         <= sel_next;
            frame_r       <= frame_next;
            hdr_ready_r   <= hdr_ready_next;
            pay_ready_r   <= pay_ready_next;
            m_hdr_valid_r <= m_hdr_valid_next;
            ready_int_r   <= ready_early;
            out_valid_r   <= out_valid_next;
            tmp_valid_r   <= tmp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            m_dest_r <= dest_v[select];
            m_src_r  <= src_v[select];
            m_type_r <= type_v[select];
        end
        if (store_int_out) begin
            out_data_r <= cur_data;
            out_last_r <= cur_last;
        end else if (store_tmp_out) begin
            out_data_r <= tmp_data_r;
            out_last_r <= tmp_last_r;
        end
        if (store_int_tmp) begin
            tmp_data_r <= cur_data;
            tmp_last_r <= cur_last;
        end
    end

    assign m.hdr_valid = m_hdr_valid_r;
    assign m.dest_mac  = m_dest_r;
    assign m.src_mac   = m_src_r;
    assign m.eth_type  = m_type_r;
    assign m.data      = out_data_r;
    assign m.valid     = out_valid_r;
    assign m.last      = out_last_r;

endmodule

// ==== verilog/eth_frame_serializer.sv ====
`timescale 1ns/10ps

module eth_frame_serializer (
    input  logic           clk,
    input  logic           rst,
    eth_frame_if.sink      s,
    output eth_pkg::byte_t out_data,
    output logic           out_valid,
    input  logic           out_ready,
    output logic           out_last
);
    import eth_pkg::*;

    ser_state_t state;

    // header bytes, first byte to send in the top byte
    logic [8*hdr_bytes-1:0] hdr_sr;
    hdr_cnt_t               hdr_cnt;

    logic hdr_xfer;
    logic hdr_byte_xfer;
    logic pay_last_xfer;

    assign hdr_xfer      = s.hdr_valid && s.hdr_ready;
    assign hdr_byte_xfer = (state == ser_header) && out_ready;
    assign pay_last_xfer = (state == ser_payload) && s.valid && out_ready && s.last;

    always_comb begin
        s.hdr_ready = 1'b0;
        s.ready     = 1'b0;
        out_data    = hdr_sr[8*hdr_bytes-1 -: 8];
        out_valid   = 1'b0;
        out_last    = 1'b0;
        case (state)
            ser_idle: begin
                s.hdr_ready = 1'b1;
            end
            ser_header: begin
                out_valid = 1'b1;
            end
            ser_payload: begin
                // payload passes straight through from the mux register
                out_data  = s.data;
                out_valid = s.valid;
                out_last  = s.last;
                s.ready   = out_ready;
            end
            default: begin
                s.hdr_ready = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ser_idle;
            hdr_cnt <= '0;
        end else begin
            case (state)
                ser_idle: begin
                    if (hdr_xfer) begin
                        state   <= ser_header;
                        hdr_cnt <= '0;
                    end
                end
                ser_header: begin
                    if (hdr_byte_xfer) begin
                        hdr_cnt <= hdr_cnt + 1'b1;
                        if (hdr_cnt == hdr_cnt_t'(hdr_bytes - 1)) begin
                            state <= ser_payload;
                        end
                    end
                end
                ser_payload: begin
                    if (pay_last_xfer) begin
                        state <= ser_idle;
                    end
                end
                default: begin
                    state <= ser_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            hdr_sr <= {s.dest_mac, s.src_mac, s.eth_type};
        end else if (hdr_byte_xfer) begin
            hdr_sr <= hdr_sr << 8;
        end
    end

endmodule

// ==== verilog/eth_mux_top.sv ====
`timescale 1ns/10ps

module eth_mux_top (
    input  logic               clk,
    input  logic               rst,

    input  logic               s0_hdr_valid,
    output logic               s0_hdr_ready,
    input  eth_pkg::mac_t      s0_dest_mac,
    input  eth_pkg::mac_t      s0_src_mac,
    input  eth_pkg::ethtype_t  s0_type,
    input  eth_pkg::byte_t     s0_data,
    input  logic               s0_valid,
    output logic               s0_ready,
    input  logic               s0_last,

    input  logic               s1_hdr_valid,
    output logic               s1_hdr_ready,
    input  eth_pkg::mac_t      s1_dest_mac,
    input  eth_pkg::mac_t      s1_src_mac,
    input  eth_pkg::ethtype_t  s1_type,
    input  eth_pkg::byte_t     s1_data,
    input  logic               s1_valid,
    output logic               s1_ready,
    input  logic               s1_last,

    input  logic               enable,
    input  eth_pkg::port_sel_t select,

    output eth_pkg::byte_t     out_data,
    output logic               out_valid,
    input  logic               out_ready,
    output logic               out_last
);
    import eth_pkg::*;

    // one link per buffered port, one from the mux to the serializer
    eth_frame_if port_if [port_count] ();
    eth_frame_if mux_if ();

    eth_frame_fifo fifo0_i (
        .clk          (clk),
        .rst          (rst),
        .in_hdr_valid (s0_hdr_valid),
        .in_hdr_ready (s0_hdr_ready),
        .in_dest_mac  (s0_dest_mac),
        .in_src_mac   (s0_src_mac),
        .in_type      (s0_type),
        .in_data      (s0_data),
        .in_valid     (s0_valid),
        .in_ready     (s0_ready),
        .in_last      (s0_last),
        .out          (port_if[0])
    );

    eth_frame_fifo fifo1_i (
        .clk          (clk),
        .rst          (rst),
        .in_hdr_valid (s1_hdr_valid),
        .in_hdr_ready (s1_hdr_ready),
        .in_dest_mac  (s1_dest_mac),
        .in_src_mac   (s1_src_mac),
        .in_type      (s1_type),
        .in_data      (s1_data),
        .in_valid     (s1_valid),
        .in_ready     (s1_ready),
        .in_last      (s1_last),
        .out          (port_if[1])
    );

    eth_mux mux_i (
        .clk    (clk),
        .rst    (rst),
        .s0     (port_if[0]),
        .s1     (port_if[1]),
        .m      (mux_if),
        .enable (enable),
        .select (select)
    );

    eth_frame_serializer ser_i (
        .clk       (clk),
        .rst       (rst),
        .s         (mux_if),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last)
    );

endmodule

// ==== verif/eth_mux_tb.sv ====
`timescale 1ns/10ps

module eth_mux_tb;
    import eth_pkg::*;

    localparam int clk_period      = 100;
    // 1 single, 5 selection, 1 enable gating, 30 back-pressure
    localparam int total_frames    = 37;
    localparam int watchdog_cycles = 200 * total_frames;
    localparam int max_frames      = 64;

    logic      clk;
    logic      rst;
    logic      hdr_valid_d [2];
    logic      hdr_ready_o [2];
    mac_t      dest_d [2];
    mac_t      src_d [2];
    ethtype_t  type_d [2];
    byte_t     data_d [2];
    logic      valid_d [2];
    logic      ready_o [2];
    logic      last_d [2];
    logic      enable;
    port_sel_t select;
    byte_t     out_data;
    logic      out_valid;
    logic      out_ready;
    logic      out_last;

    // frames in launch order, payloads packed into one store
    int        f_port [max_frames];
    mac_t      f_dest [max_frames];
    mac_t      f_src [max_frames];
    ethtype_t  f_type [max_frames];
    int        pay_base [max_frames];
    int        pay_len [max_frames];
    byte_t     pay_mem [2048];
    int        pay_top = 0;
    int        n_frames = 0;
    int        launched = 0;
    logic      stall_en;

    // checker state
    int        frames_done = 0;
    int        byte_idx = 0;
    int        stall_cnt = 0;
    byte_t     exp_data;
    logic      exp_last;

    eth_mux_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .s0_hdr_valid (hdr_valid_d[0]),
        .s0_hdr_ready (hdr_ready_o[0]),
        .s0_dest_mac  (dest_d[0]),
        .s0_src_mac   (src_d[0]),
        .s0_type      (type_d[0]),
        .s0_data      (data_d[0]),
        .s0_valid     (valid_d[0]),
        .s0_ready     (ready_o[0]),
        .s0_last      (last_d[0]),
        .s1_hdr_valid (hdr_valid_d[1]),
        .s1_hdr_ready (hdr_ready_o[1]),
        .s1_dest_mac  (dest_d[1]),
        .s1_src_mac   (src_d[1]),
        .s1_type      (type_d[1]),
        .s1_data      (data_d[1]),
        .s1_valid     (valid_d[1]),
        .s1_ready     (ready_o[1]),
        .s1_last      (last_d[1]),
        .enable       (enable),
        .select       (select),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_last     (out_last)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    // expected byte idx of frame k: dest, src, type msb first, then payload
    function automatic byte_t ref_byte(input int k, input int idx);
        if (idx < 6) begin
            return f_dest[k][47 - 8 * idx -: 8];
        end else if (idx < 12) begin
            return f_src[k][47 - 8 * (idx - 6) -: 8];
        end else if (idx < hdr_bytes) begin
            return f_type[k][15 - 8 * (idx - 12) -: 8];
        end
        return pay_mem[pay_base[k] + idx - hdr_bytes];
    endfunction

    task automatic add_frame(input int port, input int len);
        f_port[n_frames]   = port;
        f_dest[n_frames]   = mac_t'({$urandom, $urandom});
        f_src[n_frames]    = mac_t'({$urandom, $urandom});
        f_type[n_frames]   = ethtype_t'($urandom);
        pay_base[n_frames] = pay_top;
        pay_len[n_frames]  = len;
        for (int i = 0; i < len; i++) begin
            pay_mem[pay_top + i] = byte_t'($urandom);
        end
        pay_top  = pay_top + len;
        n_frames = n_frames + 1;
    endtask

    task automatic send_frame(input int n, input int k);
        int gap;
        repeat ($urandom_range(0, 3)) @(posedge clk);
        hdr_valid_d[n] <= 1'b1;
        dest_d[n]      <= f_dest[k];
        src_d[n]       <= f_src[k];
        type_d[n]      <= f_type[k];
        @(negedge clk);
        while (!hdr_ready_o[n]) @(negedge clk);
        @(posedge clk);
        hdr_valid_d[n] <= 1'b0;
        for (int i = 0; i < pay_len[k]; i++) begin
            gap = $urandom_range(0, 3);
            // idle a cycle now and then
            if (gap == 0) begin
                valid_d[n] <= 1'b0;
                @(posedge clk);
            end
            data_d[n]  <= pay_mem[pay_base[k] + i];
            last_d[n]  <= (i == pay_len[k] - 1);
            valid_d[n] <= 1'b1;
            @(negedge clk);
            while (!ready_o[n]) @(negedge clk);
            @(posedge clk);
        end
        valid_d[n] <= 1'b0;
        last_d[n]  <= 1'b0;
    endtask

    // each port sends its own frames of the list in order
    task automatic drive_port(input int n);
        int k;
        k = 0;
        forever begin
            @(posedge clk);
            if (k < n_frames) begin
                if (f_port[k] == n) begin
                    send_frame(n, k);
                end
                k++;
            end
        end
    endtask

    task automatic drive_out_ready();
        forever begin
            @(posedge clk);
            if (stall_en) begin
                out_ready <= ($urandom_range(0, 1) == 1);
            end else begin
                out_ready <= 1'b1;
            end
        end
    endtask

    // one cycle enable pulse once the port header waits, then a stray select change
    task automatic launch_frame(input int k);
        @(negedge clk);
        while (hdr_ready_o[f_port[k]]) @(negedge clk);
        @(posedge clk);
        select <= port_sel_t'(f_port[k]);
        enable <= 1'b1;
        @(posedge clk);
        enable <= 1'b0;
        select <= port_sel_t'(1 - f_port[k]);
    endtask

    task automatic run_pending();
        while (launched < n_frames) begin
            while (frames_done < launched) @(negedge clk);
            launch_frame(launched);
            launched++;
        end
        while (frames_done < n_frames) @(negedge clk);
    endtask

    // nothing is accepted or sent around reset
    task automatic check_reset_outputs();
        assert (out_valid == 1'b0)
            else abort_run($sformatf("Error: out_valid expected %h, got %h", 1'b0, out_valid));
        for (int n = 0; n < port_count; n++) begin
            assert (hdr_ready_o[n] == 1'b0)
                else abort_run($sformatf("Error: s%0d_hdr_ready expected %h, got %h",
                                         n, 1'b0, hdr_ready_o[n]));
            assert (ready_o[n] == 1'b0)
                else abort_run($sformatf("Error: s%0d_ready expected %h, got %h",
                                         n, 1'b0, ready_o[n]));
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if ((valid_d[0] && !ready_o[0]) || (valid_d[1] && !ready_o[1])) begin
                stall_cnt++;
            end
            if (out_valid && out_ready) begin
                assert (frames_done < launched)
                    else abort_run("an output byte arrived with no frame launched");
                exp_data = ref_byte(frames_done, byte_idx);
                exp_last = (byte_idx == hdr_bytes + pay_len[frames_done] - 1);
                assert (out_data == exp_data)
                    else abort_run($sformatf("Error: out_data expected %h, got %h (frame %0d)",
                                             exp_data, out_data, frames_done));
                assert (out_last == exp_last)
                    else abort_run($sformatf("Error: out_last expected %h, got %h (frame %0d)",
                                             exp_last, out_last, frames_done));
                if (exp_last) begin
                    frames_done++;
                    byte_idx = 0;
                end else begin
                    byte_idx++;
                end
            end
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        abort_run("timeout: the frames did not all come out in time");
    end

    initial begin
        void'($urandom(32'he5d4));
        clk       = 1'b0;
        rst       = 1'b1;
        enable    = 1'b0;
        select    = '0;
        out_ready = 1'b0;
        stall_en  = 1'b0;
        for (int n = 0; n < 2; n++) begin
            hdr_valid_d[n] = 1'b0;
            dest_d[n]      = '0;
            src_d[n]       = '0;
            type_d[n]      = '0;
            data_d[n]      = '0;
            valid_d[n]     = 1'b0;
            last_d[n]      = 1'b0;
        end
        fork
            drive_port(0);
            drive_port(1);
            drive_out_ready();
        join_none

        @(posedge clk);
        @(negedge clk);
        check_reset_outputs();
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_reset_outputs();

        add_frame(0, $urandom_range(1, 20));
        run_pending();

        // frames wait on both ports, select alternates between them
        add_frame(0, $urandom_range(1, 20));
        add_frame(1, $urandom_range(1, 20));
        add_frame(1, $urandom_range(1, 20));
        add_frame(0, $urandom_range(1, 20));
        add_frame(1, $urandom_range(1, 20));
        run_pending();

        // long frame held back by enable, fills the port buffer
        @(posedge clk);
        select <= port_sel_t'(1);
        add_frame(1, 20);
        @(negedge clk);
        while (hdr_ready_o[1]) @(negedge clk);
        repeat (30) begin
            @(negedge clk);
            assert (out_valid == 1'b0)
                else abort_run($sformatf("Error: out_valid expected %h, got %h",
                                         1'b0, out_valid));
        end
        run_pending();

        stall_en = 1'b1;
        repeat (30) begin
            add_frame($urandom_range(0, 1), $urandom_range(1, 20));
        end
        run_pending();

        assert (stall_cnt > 0)
            else abort_run("the sources never stalled on a full buffer");
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/eth_pkg.sv
verilog/eth_frame_if.sv
verilog/eth_frame_fifo.sv
verilog/eth_mux.sv
verilog/eth_frame_serializer.sv
verilog/eth_mux_top.sv
verif/eth_mux_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it, the exit status carries the result
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module eth_mux_tb -f verilog.f -o eth_mux_sim &&
./obj_dir/eth_mux_sim || exit 1
